//--- filelist.f
hw/bus_map_pkg.sv
hw/sys_ctrl_pkg.sv
hw/dma_arbiter.sv
hw/master_mux.sv
hw/addr_decoder.sv
hw/timer_irq_gate.sv
hw/bus_fabric_top.sv
tests/tb_bus_fabric.sv

//--- tests/tb_bus_fabric.sv
// self-checking testbench for the shared bus core
// rom, ram, uart and the two register blocks are modelled here
// each device acks one cycle after its strobe, data = address ^ device key
// register addresses are octal as on the real machine

`timescale 1ns/1ns

module tb_bus_fabric;

   localparam int N_READS      = 200;
   localparam int N_WRITES     = 50;
   localparam int N_DMA        = 8;     // transfers per dma master
   localparam int N_TRANS      = N_READS + N_WRITES + 2 * N_DMA + 2;
   localparam int ACK_WAIT     = 20;    // cycles before an ack counts as lost
   localparam int TICK         = sys_ctrl_pkg::TICK_DIV;
   localparam int WATCHDOG_CYC = N_TRANS * 10 + 8 * TICK + 1000;
   localparam logic [31:0] SEED = 32'd79733;

   logic        wb_clk, rst_n_i;
   logic [16:0] cpu_adr_i;
   logic [15:0] cpu_dat_i;
   logic        cpu_cyc_i, cpu_we_i, cpu_stb_i, cpu_ack_o, cpu_gnt_o;
   logic [1:0]  cpu_sel_i;
   logic        rk_dma_req_i, rk_we_i, rk_stb_i, rk_ack_o, rk_gnt_o;
   logic [15:0] rk_adr_i, rk_dat_i;
   logic        my_dma_req_i, my_we_i, my_stb_i, my_ack_o, my_gnt_o;
   logic [15:0] my_adr_i, my_dat_i;
   logic [16:0] bus_adr_o;
   logic [15:0] bus_dat_o, rd_dat_o;
   logic        bus_we_o;
   logic [1:0]  bus_sel_o;
   logic        rom_stb_o, ram_stb_o, uart_stb_o, rk_reg_stb_o, my_reg_stb_o;
   logic [15:0] rom_dat_i, ram_dat_i, uart_dat_i, rk_reg_dat_i, my_reg_dat_i;
   logic        rom_ack_i, ram_ack_i, uart_ack_i, rk_reg_ack_i, my_reg_ack_i;
   logic        timer_key_i, timer_irq_o, timer_on_o;

   logic [4:0]  dev_stb;    // {my, rk, uart, ram, rom}
   logic [4:0]  dev_ack;
   logic        ack_hold;   // devices keep ack low while set
   logic [2:0]  gnt_vec;    // {my, rk, cpu}
   logic [2:0]  ack_vec;
   logic [31:0] rng;
   int          cur_master; // 0 cpu, 1 rk, 2 my
   logic [16:0] cur_adr;
   logic        cur_we;
   logic [15:0] cur_dat;
   logic [1:0]  cur_sel;
   int          n_errors;
   int          n_acks;

   bus_fabric_top i_dut (.*);

   initial wb_clk = 1'b0;
   always #5 wb_clk = ~wb_clk;   // 10 ns period

   assign dev_stb = {my_reg_stb_o, rk_reg_stb_o, uart_stb_o, ram_stb_o, rom_stb_o};
   assign {my_reg_ack_i, rk_reg_ack_i, uart_ack_i, ram_ack_i, rom_ack_i} = dev_ack;
   assign gnt_vec = {my_gnt_o, rk_gnt_o, cpu_gnt_o};
   assign ack_vec = {my_ack_o, rk_ack_o, cpu_ack_o};

   //****************************************
   //* reference model
   //****************************************
   function automatic bus_map_pkg::dev_e exp_dev(input logic [16:0] a);
      if (a >= 17'h1c000 && a < 17'h1e000) return bus_map_pkg::DEV_ROM;   // shadow monitor
      if ((!a[16] && a < 17'h0e000) || a >= 17'h1e000) return bus_map_pkg::DEV_RAM;
      if (a >= 17'o177560 && a <= 17'o177567) return bus_map_pkg::DEV_UART;
      if (a >= 17'o177400 && a <= 17'o177417) return bus_map_pkg::DEV_RK;
      if (a >= 17'o172140 && a <= 17'o172143) return bus_map_pkg::DEV_MY;
      return bus_map_pkg::DEV_NONE;
   endfunction

   function automatic logic [15:0] dev_key(input bus_map_pkg::dev_e d);
      case (d)
         bus_map_pkg::DEV_ROM:  return 16'hc3a5;
         bus_map_pkg::DEV_RAM:  return 16'h5a17;
         bus_map_pkg::DEV_UART: return 16'h0f0f;
         bus_map_pkg::DEV_RK:   return 16'h9264;
         bus_map_pkg::DEV_MY:   return 16'h3c81;
         default:               return 16'h0000;
      endcase
   endfunction

   function automatic logic [15:0] exp_data(input logic [16:0] a);
      return a[15:0] ^ dev_key(exp_dev(a));
   endfunction

   function automatic logic [4:0] exp_strobes(input bus_map_pkg::dev_e d);
      case (d)
         bus_map_pkg::DEV_ROM:  return 5'b00001;
         bus_map_pkg::DEV_RAM:  return 5'b00010;
         bus_map_pkg::DEV_UART: return 5'b00100;
         bus_map_pkg::DEV_RK:   return 5'b01000;
         bus_map_pkg::DEV_MY:   return 5'b10000;
         default:               return 5'b00000;
      endcase
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   //****************************************
   //* device models
   //****************************************
   assign rom_dat_i    = bus_adr_o[15:0] ^ dev_key(bus_map_pkg::DEV_ROM);
   assign ram_dat_i    = bus_adr_o[15:0] ^ dev_key(bus_map_pkg::DEV_RAM);
   assign uart_dat_i   = bus_adr_o[15:0] ^ dev_key(bus_map_pkg::DEV_UART);
   assign rk_reg_dat_i = bus_adr_o[15:0] ^ dev_key(bus_map_pkg::DEV_RK);
   assign my_reg_dat_i = bus_adr_o[15:0] ^ dev_key(bus_map_pkg::DEV_MY);

   always @(posedge wb_clk) begin : device_model
      logic [4:0] seen;
      seen = dev_stb;
      #1;
      dev_ack = seen & ~dev_ack & {5{~ack_hold}};   // single cycle ack
   end

   //****************************************
   //* reporting
   //****************************************
   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      n_errors++;
      $display("FAIL %s expected %h got %h at %0t", name, exp_v, act_v, $time);
   endtask

   task automatic report_error(input string msg);
      n_errors++;
      $display("ERROR %s at %0t", msg, $time);
   endtask

   task automatic print_summary();
      $display("acks checked %0d, errors %0d", n_acks, n_errors);
   endtask

   // compare at every ack, mid cycle where all outputs are settled
   always @(negedge wb_clk) begin : compare
      bus_map_pkg::dev_e dev;
      if (rst_n_i && ack_vec != 3'b000) begin
         n_acks++;
         dev = exp_dev(cur_adr);
         if (ack_vec != (3'b001 << cur_master)) begin
            report_mismatch("{my,rk,cpu}_ack_o", 3'b001 << cur_master, ack_vec);
         end
         if (dev_stb != exp_strobes(dev)) begin
            report_mismatch("{my_reg,rk_reg,uart,ram,rom}_stb_o", exp_strobes(dev), dev_stb);
         end
         if (bus_adr_o != cur_adr) report_mismatch("bus_adr_o", cur_adr, bus_adr_o);
         if (bus_we_o != cur_we) report_mismatch("bus_we_o", cur_we, bus_we_o);
         if (bus_sel_o != cur_sel) report_mismatch("bus_sel_o", cur_sel, bus_sel_o);
         if (cur_we && bus_dat_o != cur_dat) report_mismatch("bus_dat_o", cur_dat, bus_dat_o);
         if (!cur_we && rd_dat_o != exp_data(cur_adr)) begin
            report_mismatch("rd_dat_o", exp_data(cur_adr), rd_dat_o);
         end
      end
   end

   //****************************************
   //* master tasks
   //****************************************
   task automatic bus_access(input int m, input logic [16:0] adr, input logic we,
                             input logic [15:0] dat, input logic [1:0] sel);
      int n;
      @(posedge wb_clk);
      #1;
      cur_master = m;
      cur_we     = we;
      cur_dat    = dat;
      cur_adr    = (m == 0) ? adr : {1'b0, adr[15:0]};   // dma is zero-extended
      cur_sel    = (m == 0) ? sel : 2'b11;               // dma moves whole words
      if (m == 0) begin
         cpu_adr_i = adr;
         cpu_we_i  = we;
         cpu_dat_i = dat;
         cpu_sel_i = sel;
         cpu_cyc_i = 1'b1;
         cpu_stb_i = 1'b1;
      end else if (m == 1) begin
         rk_adr_i = adr[15:0];
         rk_we_i  = we;
         rk_dat_i = dat;
         rk_stb_i = 1'b1;
      end else begin
         my_adr_i = adr[15:0];
         my_we_i  = we;
         my_dat_i = dat;
         my_stb_i = 1'b1;
      end
      n = 0;
      do begin
         @(negedge wb_clk);
         n++;
      end while (!ack_vec[m] && n < ACK_WAIT);
      if (!ack_vec[m]) report_error($sformatf("master %0d got no ack at %h", m, adr));
      @(posedge wb_clk);
      #1;
      cpu_cyc_i = 1'b0;
      cpu_stb_i = 1'b0;
      cpu_we_i  = 1'b0;
      cpu_sel_i = 2'b00;   // idle processor shows no byte lanes
      rk_stb_i  = 1'b0;
      my_stb_i  = 1'b0;
   endtask

   task automatic next_mapped_adr(input logic dma_only, output logic [16:0] adr);
      do begin
         rng = xorshift32(rng);
         case (rng[31:29])
            3'd5:    adr = 17'o177560 | 17'(rng[2:0]);   // uart
            3'd6:    adr = 17'o177400 | 17'(rng[3:0]);   // rk registers
            3'd7:    adr = 17'o172140 | 17'(rng[1:0]);   // my registers
            default: adr = rng[16:0];
         endcase
         if (dma_only) adr[16] = 1'b0;   // no console bit on dma
      end while (exp_dev(adr) == bus_map_pkg::DEV_NONE);
   endtask

   task automatic wait_for_grant(input int m, input string what);
      int n;
      n = 0;
      @(negedge wb_clk);
      while (gnt_vec != (3'b001 << m) && n < ACK_WAIT) begin
         @(negedge wb_clk);
         n++;
      end
      if (gnt_vec != (3'b001 << m)) report_error({what, " never arrived"});
   endtask

   // counts irq pulses over a window, consecutive pulses must be one tick apart
   task automatic count_irq(input int cycles, output int pulses);
      int last;
      pulses = 0;
      last   = -1;
      for (int i = 0; i < cycles; i++) begin
         @(negedge wb_clk);
         if (timer_irq_o) begin
            if (last >= 0 && i - last != TICK) report_mismatch("irq spacing", TICK, i - last);
            last = i;
            pulses++;
         end
      end
   endtask

   //****************************************
   //* stimulus
   //****************************************
   initial begin
      logic [16:0] adr;
      logic [1:0]  sel;
      int          n;
      rst_n_i = 1'b0;
      {cpu_adr_i, cpu_dat_i, cpu_cyc_i, cpu_we_i, cpu_sel_i, cpu_stb_i} = '0;
      {rk_dma_req_i, rk_adr_i, rk_dat_i, rk_we_i, rk_stb_i} = '0;
      {my_dma_req_i, my_adr_i, my_dat_i, my_we_i, my_stb_i} = '0;
      timer_key_i = 1'b0;
      dev_ack     = '0;
      ack_hold    = 1'b0;
      rng         = SEED;
      n_errors    = 0;
      n_acks      = 0;
      repeat (16) @(posedge wb_clk);
      #1 rst_n_i = 1'b1;

      // state straight after reset
      @(negedge wb_clk);
      if (gnt_vec != 3'b001) report_mismatch("{my,rk,cpu}_gnt_o", 3'b001, gnt_vec);
      if (dev_stb != 5'b00000) begin
         report_mismatch("{my_reg,rk_reg,uart,ram,rom}_stb_o", 0, dev_stb);
      end
      if (timer_irq_o !== 1'b0) report_mismatch("timer_irq_o", 0, timer_irq_o);
      if (timer_on_o !== 1'b1) report_mismatch("timer_on_o", 1, timer_on_o);

      // processor reads and writes, both modes
      for (int i = 0; i < N_READS; i++) begin
         next_mapped_adr(1'b0, adr);
         bus_access(0, adr, 1'b0, 16'h0000, 2'b11);
      end
      for (int i = 0; i < N_WRITES; i++) begin
         next_mapped_adr(1'b0, adr);
         rng = xorshift32(rng);
         sel = (rng[17:16] == 2'b00) ? 2'b11 : rng[17:16];
         bus_access(0, adr, 1'b1, rng[15:0], sel);
      end

      // both dma masters at once, rk first then my
      @(posedge wb_clk);
      #1;
      rk_dma_req_i = 1'b1;
      my_dma_req_i = 1'b1;
      wait_for_grant(1, "rk grant with both requests up");
      for (int i = 0; i < N_DMA; i++) begin
         next_mapped_adr(1'b1, adr);
         rng = xorshift32(rng);
         bus_access(1, adr, rng[31], rng[15:0], 2'b11);
      end
      @(posedge wb_clk);
      #1 rk_dma_req_i = 1'b0;
      wait_for_grant(2, "my grant after rk released");
      for (int i = 0; i < N_DMA; i++) begin
         next_mapped_adr(1'b1, adr);
         rng = xorshift32(rng);
         bus_access(2, adr, rng[31], rng[15:0], 2'b11);
      end
      @(posedge wb_clk);
      #1 my_dma_req_i = 1'b0;
      wait_for_grant(0, "processor grant after dma");

      // dma request during a stalled processor cycle
      ack_hold = 1'b1;
      fork
         bus_access(0, 17'h00100, 1'b0, 16'h0000, 2'b11);
         begin
            repeat (2) @(posedge wb_clk);
            #1 rk_dma_req_i = 1'b1;
            repeat (5) begin
               @(negedge wb_clk);
               if (gnt_vec != 3'b001) report_mismatch("{my,rk,cpu}_gnt_o", 3'b001, gnt_vec);
            end
            ack_hold = 1'b0;   // let the ram finish
         end
      join
      @(negedge wb_clk);   // cyc just fell, owner not yet re-evaluated
      if (gnt_vec != 3'b001) report_mismatch("{my,rk,cpu}_gnt_o", 3'b001, gnt_vec);
      wait_for_grant(1, "rk grant after the processor cycle");
      @(posedge wb_clk);
      #1 rk_dma_req_i = 1'b0;
      wait_for_grant(0, "processor grant after rk");

      // interval timer and key toggle
      count_irq(4 * TICK, n);
      if (n != 4) report_mismatch("timer_irq_o pulses", 4, n);
      @(posedge wb_clk);
      #1 timer_key_i = 1'b1;
      count_irq(3 * TICK, n);   // toggles off on the second agreeing sample
      if (timer_on_o !== 1'b0) report_mismatch("timer_on_o", 0, timer_on_o);
      @(posedge wb_clk);
      #1 timer_key_i = 1'b0;
      count_irq(3 * TICK, n);
      if (n != 0) report_mismatch("timer_irq_o pulses", 0, n);
      @(posedge wb_clk);
      #1 timer_key_i = 1'b1;
      count_irq(3 * TICK, n);
      @(posedge wb_clk);
      #1 timer_key_i = 1'b0;
      if (timer_on_o !== 1'b1) report_mismatch("timer_on_o", 1, timer_on_o);
      count_irq(2 * TICK, n);
      if (n != 2) report_mismatch("timer_irq_o pulses", 2, n);

      print_summary();
      if (n_errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYC) @(posedge wb_clk);
      report_error("watchdog expired before the tests finished");
      print_summary();
      $display("sim failed");
      $finish;
   end

endmodule

//--- hw/bus_fabric_top.sv
// shared bus core: dma arbiter, master mux, address decoder, timer gate
// device register blocks of rk and my sit behind the *_reg_* ports
// console mode is bit 16 of the processor address

`timescale 1ns/1ns

module bus_fabric_top (
   input  logic                              wb_clk,
   input  logic                              rst_n_i,
   // processor master
   input  logic [bus_map_pkg::ADR_W-1:0]     cpu_adr_i,
   input  logic [bus_map_pkg::DAT_W-1:0]     cpu_dat_i,
   input  logic                              cpu_cyc_i,
   input  logic                              cpu_we_i,
   input  logic [bus_map_pkg::SEL_W-1:0]     cpu_sel_i,
   input  logic                              cpu_stb_i,
   output logic                              cpu_ack_o,
   output logic                              cpu_gnt_o,
   // rk dma master
   input  logic                              rk_dma_req_i,
   input  logic [bus_map_pkg::DMA_ADR_W-1:0] rk_adr_i,
   input  logic [bus_map_pkg::DAT_W-1:0]     rk_dat_i,
   input  logic                              rk_we_i,
   input  logic                              rk_stb_i,
   output logic                              rk_ack_o,
   output logic                              rk_gnt_o,
   // my dma master
   input  logic                              my_dma_req_i,
   input  logic [bus_map_pkg::DMA_ADR_W-1:0] my_adr_i,
   input  logic [bus_map_pkg::DAT_W-1:0]     my_dat_i,
   input  logic                              my_we_i,
   input  logic                              my_stb_i,
   output logic                              my_ack_o,
   output logic                              my_gnt_o,
   // shared bus to devices
   output logic [bus_map_pkg::ADR_W-1:0]     bus_adr_o,
   output logic [bus_map_pkg::DAT_W-1:0]     bus_dat_o,
   output logic                              bus_we_o,
   output logic [bus_map_pkg::SEL_W-1:0]     bus_sel_o,
   output logic [bus_map_pkg::DAT_W-1:0]     rd_dat_o,    // to all masters
   // device strobes
   output logic                              rom_stb_o,
   output logic                              ram_stb_o,
   output logic                              uart_stb_o,
   output logic                              rk_reg_stb_o,
   output logic                              my_reg_stb_o,
   // device read data
   input  logic [bus_map_pkg::DAT_W-1:0]     rom_dat_i,
   input  logic [bus_map_pkg::DAT_W-1:0]     ram_dat_i,
   input  logic [bus_map_pkg::DAT_W-1:0]     uart_dat_i,
   input  logic [bus_map_pkg::DAT_W-1:0]     rk_reg_dat_i,
   input  logic [bus_map_pkg::DAT_W-1:0]     my_reg_dat_i,
   // device acks
   input  logic                              rom_ack_i,
   input  logic                              ram_ack_i,
   input  logic                              uart_ack_i,
   input  logic                              rk_reg_ack_i,
   input  logic                              my_reg_ack_i,
   // interval timer
   input  logic                              timer_key_i,
   output logic                              timer_irq_o,
   output logic                              timer_on_o
);

   sys_ctrl_pkg::owner_e owner;   // arbiter to mux
   logic                 bus_cyc; // shared cyc
   logic                 bus_stb; // shared stb
   logic                 bus_ack; // or of device acks

   //****************************************
   //* ownership
   //****************************************
   dma_arbiter i_arbiter (
      .wb_clk    (wb_clk),
      .rst_n_i   (rst_n_i),
      .bus_cyc_i (bus_cyc),
      .rk_req_i  (rk_dma_req_i),
      .my_req_i  (my_dma_req_i),
      .owner_o   (owner),
      .cpu_gnt_o (cpu_gnt_o),
      .rk_gnt_o  (rk_gnt_o),
      .my_gnt_o  (my_gnt_o)
   );

   master_mux i_mux (
      .owner_i   (owner),
      .cpu_adr_i (cpu_adr_i),
      .cpu_dat_i (cpu_dat_i),
      .cpu_cyc_i (cpu_cyc_i),
      .cpu_we_i  (cpu_we_i),
      .cpu_sel_i (cpu_sel_i),
      .cpu_stb_i (cpu_stb_i),
      .rk_adr_i  (rk_adr_i),
      .rk_dat_i  (rk_dat_i),
      .rk_req_i  (rk_dma_req_i),
      .rk_we_i   (rk_we_i),
      .rk_stb_i  (rk_stb_i),
      .my_adr_i  (my_adr_i),
      .my_dat_i  (my_dat_i),
      .my_req_i  (my_dma_req_i),
      .my_we_i   (my_we_i),
      .my_stb_i  (my_stb_i),
      .bus_ack_i (bus_ack),
      .bus_adr_o (bus_adr_o),
      .bus_dat_o (bus_dat_o),
      .bus_cyc_o (bus_cyc),
      .bus_we_o  (bus_we_o),
      .bus_sel_o (bus_sel_o),
      .bus_stb_o (bus_stb),
      .cpu_ack_o (cpu_ack_o),
      .rk_ack_o  (rk_ack_o),
      .my_ack_o  (my_ack_o)
   );

   //****************************************
   //* device side
   //****************************************
   addr_decoder i_decoder (
      .bus_adr_i  (bus_adr_o),
      .bus_cyc_i  (bus_cyc),
      .bus_stb_i  (bus_stb),
      .rom_dat_i  (rom_dat_i),
      .ram_dat_i  (ram_dat_i),
      .uart_dat_i (uart_dat_i),
      .rk_dat_i   (rk_reg_dat_i),
      .my_dat_i   (my_reg_dat_i),
      .rom_ack_i  (rom_ack_i),
      .ram_ack_i  (ram_ack_i),
      .uart_ack_i (uart_ack_i),
      .rk_ack_i   (rk_reg_ack_i),
      .my_ack_i   (my_reg_ack_i),
      .rom_stb_o  (rom_stb_o),
      .ram_stb_o  (ram_stb_o),
      .uart_stb_o (uart_stb_o),
      .rk_stb_o   (rk_reg_stb_o),
      .my_stb_o   (my_reg_stb_o),
      .bus_ack_o  (bus_ack),
      .rd_dat_o   (rd_dat_o)
   );

   timer_irq_gate i_timer (
      .wb_clk      (wb_clk),
      .rst_n_i     (rst_n_i),
      .timer_key_i (timer_key_i),
      .timer_irq_o (timer_irq_o),
      .timer_on_o  (timer_on_o)
   );

endmodule

//--- hw/timer_irq_gate.sv
// interval timer tick with a key toggled enable
// key must already be synchronous to wb_clk, it is sampled only on ticks
// one toggle per press, re-armed after a stable release

`timescale 1ns/1ns

module timer_irq_gate (
   input  logic wb_clk,
   input  logic rst_n_i,
   input  logic timer_key_i,   // high while pressed
   output logic timer_irq_o,   // one cycle per tick while enabled
   output logic timer_on_o     // enable indicator
);

   logic [sys_ctrl_pkg::TICK_CNT_W-1:0] cnt_q;   // prescaler
   logic                                tick;    // last prescaler state
   logic [sys_ctrl_pkg::DEB_LEN-1:0]    deb_q;   // key history, newest in bit 0
   logic [sys_ctrl_pkg::DEB_LEN-1:0]    deb_nxt; // history incl. this sample
   logic                                held_q;  // press already served
   logic                                on_q;    // timer enable

   //****************************************
   //* prescaler
   //****************************************
   assign tick = (cnt_q == sys_ctrl_pkg::TICK_CNT_W'(sys_ctrl_pkg::TICK_DIV - 1));

   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (tick) begin
         cnt_q <= '0;                  // wrap
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   //****************************************
   //* key debounce and enable toggle
   //****************************************
   assign deb_nxt = {deb_q[sys_ctrl_pkg::DEB_LEN-2:0], timer_key_i};

   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         deb_q  <= '0;
         held_q <= 1'b0;
         on_q   <= 1'b1;               // timer runs out of reset
      end else if (tick) begin
         deb_q <= deb_nxt;
         if (&deb_nxt) begin
            // stable press
            if (!held_q) on_q <= ~on_q;
            held_q <= 1'b1;            // ignore until release
         end else if (~|deb_nxt) begin
            held_q <= 1'b0;            // stable release, re-arm
         end
      end
   end

   assign timer_irq_o = tick & on_q;   // masked tick
   assign timer_on_o  = on_q;

endmodule

//--- hw/addr_decoder.sv
// device selects for rom, ram and three register blocks
// windows do not overlap, read data is an or of gated device buses
// devices must keep their ack low while not selected

`timescale 1ns/1ns

module addr_decoder (
   input  logic [bus_map_pkg::ADR_W-1:0] bus_adr_i,
   input  logic                          bus_cyc_i,
   input  logic                          bus_stb_i,
   // device read data
   input  logic [bus_map_pkg::DAT_W-1:0] rom_dat_i,
   input  logic [bus_map_pkg::DAT_W-1:0] ram_dat_i,
   input  logic [bus_map_pkg::DAT_W-1:0] uart_dat_i,
   input  logic [bus_map_pkg::DAT_W-1:0] rk_dat_i,
   input  logic [bus_map_pkg::DAT_W-1:0] my_dat_i,
   // device acks
   input  logic                          rom_ack_i,
   input  logic                          ram_ack_i,
   input  logic                          uart_ack_i,
   input  logic                          rk_ack_i,
   input  logic                          my_ack_i,
   // device strobes
   output logic                          rom_stb_o,
   output logic                          ram_stb_o,
   output logic                          uart_stb_o,
   output logic                          rk_stb_o,
   output logic                          my_stb_o,
   // return path
   output logic                          bus_ack_o,
   output logic [bus_map_pkg::DAT_W-1:0] rd_dat_o
);

   logic bus_acc;    // live transfer on the bus
   logic rom_hit;
   logic ram_hit;
   logic uart_hit;
   logic rk_hit;
   logic my_hit;

   assign bus_acc = bus_cyc_i & bus_stb_i;

   //****************************************
   //* window decode
   //****************************************

   // monitor rom in the shadow area, console mode only
   assign rom_hit  = (bus_adr_i[16:13] == bus_map_pkg::ROM_TAG);

   // user mode: low 56k, console mode: top page only
   assign ram_hit  = (bus_adr_i[15:13] != bus_map_pkg::RAM_HOLE) ^ bus_adr_i[16];

   // io page registers
   assign uart_hit = (bus_adr_i[16:3] == bus_map_pkg::UART_BASE[16:3]);  // 177560-177566
   assign rk_hit   = (bus_adr_i[16:4] == bus_map_pkg::RK_BASE[16:4]);    // 177400-177416
   assign my_hit   = (bus_adr_i[16:2] == bus_map_pkg::MY_BASE[16:2]);    // 172140-172142

   // strobes, qualified by cyc and stb
   assign rom_stb_o  = bus_acc & rom_hit;
   assign ram_stb_o  = bus_acc & ram_hit;
   assign uart_stb_o = bus_acc & uart_hit;
   assign rk_stb_o   = bus_acc & rk_hit;
   assign my_stb_o   = bus_acc & my_hit;

   //****************************************
   //* return path
   //****************************************

   // unselected devices may hold anything on their data
   always_comb begin
      rd_dat_o = '0;
      if (rom_stb_o)  rd_dat_o = rd_dat_o | rom_dat_i;
      if (ram_stb_o)  rd_dat_o = rd_dat_o | ram_dat_i;
      if (uart_stb_o) rd_dat_o = rd_dat_o | uart_dat_i;
      if (rk_stb_o)   rd_dat_o = rd_dat_o | rk_dat_i;
      if (my_stb_o)   rd_dat_o = rd_dat_o | my_dat_i;
   end

   // any device finishing ends the cycle
   assign bus_ack_o = rom_ack_i | ram_ack_i | uart_ack_i | rk_ack_i | my_ack_i;

endmodule

//--- hw/master_mux.sv
// puts the owning master onto the shared bus, purely combinational
// dma masters always move whole words, cyc of a dma owner is its request

`timescale 1ns/1ns

module master_mux (
   input  sys_ctrl_pkg::owner_e                   owner_i,
   // processor
   input  logic [bus_map_pkg::ADR_W-1:0]          cpu_adr_i,
   input  logic [bus_map_pkg::DAT_W-1:0]          cpu_dat_i,
   input  logic                                   cpu_cyc_i,
   input  logic                                   cpu_we_i,
   input  logic [bus_map_pkg::SEL_W-1:0]          cpu_sel_i,
   input  logic                                   cpu_stb_i,
   // rk dma
   input  logic [bus_map_pkg::DMA_ADR_W-1:0]      rk_adr_i,
   input  logic [bus_map_pkg::DAT_W-1:0]          rk_dat_i,
   input  logic                                   rk_req_i,
   input  logic                                   rk_we_i,
   input  logic                                   rk_stb_i,
   // my dma
   input  logic [bus_map_pkg::DMA_ADR_W-1:0]      my_adr_i,
   input  logic [bus_map_pkg::DAT_W-1:0]          my_dat_i,
   input  logic                                   my_req_i,
   input  logic                                   my_we_i,
   input  logic                                   my_stb_i,
   // shared bus
   input  logic                                   bus_ack_i,
   output logic [bus_map_pkg::ADR_W-1:0]          bus_adr_o,
   output logic [bus_map_pkg::DAT_W-1:0]          bus_dat_o,
   output logic                                   bus_cyc_o,
   output logic                                   bus_we_o,
   output logic [bus_map_pkg::SEL_W-1:0]          bus_sel_o,
   output logic                                   bus_stb_o,
   output logic                                   cpu_ack_o,
   output logic                                   rk_ack_o,
   output logic                                   my_ack_o
);

   always_comb begin
      // processor by default
      bus_adr_o = cpu_adr_i;
      bus_dat_o = cpu_dat_i;
      bus_cyc_o = cpu_cyc_i;
      bus_we_o  = cpu_we_i;
      bus_sel_o = cpu_sel_i;
      bus_stb_o = cpu_stb_i;
      cpu_ack_o = 1'b0;
      rk_ack_o  = 1'b0;
      my_ack_o  = 1'b0;
      unique case (owner_i)
         sys_ctrl_pkg::OWN_RK: begin
            bus_adr_o = {{(bus_map_pkg::ADR_W - bus_map_pkg::DMA_ADR_W){1'b0}}, rk_adr_i};
            bus_dat_o = rk_dat_i;
            bus_cyc_o = rk_req_i;      // request doubles as cycle
            bus_we_o  = rk_we_i;
            bus_sel_o = '1;            // word only
            bus_stb_o = rk_stb_i;
            rk_ack_o  = bus_ack_i;
         end
         sys_ctrl_pkg::OWN_MY: begin
            bus_adr_o = {{(bus_map_pkg::ADR_W - bus_map_pkg::DMA_ADR_W){1'b0}}, my_adr_i};
            bus_dat_o = my_dat_i;
            bus_cyc_o = my_req_i;
            bus_we_o  = my_we_i;
            bus_sel_o = '1;
            bus_stb_o = my_stb_i;
            my_ack_o  = bus_ack_i;
         end
         default: begin
            cpu_ack_o = bus_ack_i;     // ack only to the owner
         end
      endcase
   end

endmodule

//--- hw/dma_arbiter.sv
// shared bus owner selection, rk over my over processor
// owner switches only in a cycle where shared cyc is low
// a dma master must keep its request up for its whole tenure

`timescale 1ns/1ns

module dma_arbiter (
   input  logic                 wb_clk,
   input  logic                 rst_n_i,
   input  logic                 bus_cyc_i,  // shared cyc from the master mux
   input  logic                 rk_req_i,   // rk dma request
   input  logic                 my_req_i,   // my dma request
   output sys_ctrl_pkg::owner_e owner_o,
   output logic                 cpu_gnt_o,
   output logic                 rk_gnt_o,
   output logic                 my_gnt_o
);

   sys_ctrl_pkg::owner_e owner_q;   // current owner
   sys_ctrl_pkg::owner_e owner_d;   // owner after this edge

   //****************************************
   //* next owner
   //****************************************
   always_comb begin
      owner_d = owner_q;                       // hold during an active cycle
      if (!bus_cyc_i) begin
         // bus idle, re-evaluate with fixed priority
         if (rk_req_i) begin
            owner_d = sys_ctrl_pkg::OWN_RK;
         end else if (my_req_i) begin
            owner_d = sys_ctrl_pkg::OWN_MY;
         end else begin
            owner_d = sys_ctrl_pkg::OWN_CPU;   // nobody asks, bus back to cpu
         end
      end
   end

   // owner register
   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         owner_q <= sys_ctrl_pkg::OWN_CPU;
      end else begin
         owner_q <= owner_d;
      end
   end

   //****************************************
   //* grants
   //****************************************
   assign owner_o   = owner_q;
   assign cpu_gnt_o = (owner_q == sys_ctrl_pkg::OWN_CPU);  // cpu stalls when low
   assign rk_gnt_o  = (owner_q == sys_ctrl_pkg::OWN_RK);
   assign my_gnt_o  = (owner_q == sys_ctrl_pkg::OWN_MY);

endmodule

//--- hw/sys_ctrl_pkg.sv
// bus ownership codes and interval timer constants
// tick period is shortened for simulation, real board runs at 50 Hz

package sys_ctrl_pkg;

   //****************************************
   //* bus owner
   //****************************************
   typedef enum logic [1:0] {
      OWN_CPU,   // default owner, processor
      OWN_RK,    // rk disk dma, highest priority
      OWN_MY     // my floppy dma
   } owner_e;

   //****************************************
   //* interval timer
   //****************************************
   localparam int TICK_CNT_W = 8;    // prescaler width
   localparam int TICK_DIV   = 200;  // wb_clk cycles per tick, must fit TICK_CNT_W
   localparam int DEB_LEN    = 2;    // agreeing key samples, at least 2

endpackage

//--- hw/bus_map_pkg.sv
// shared bus geometry and device address windows
// addresses are word-bus byte addresses, bit 16 selects console mode
// dma masters see only a 16 bit space, upper bit is forced low

package bus_map_pkg;

   //****************************************
   //* bus widths
   //****************************************
   localparam int ADR_W     = 17;  // processor address, bit 16 = console mode
   localparam int DMA_ADR_W = 16;  // dma masters, zero-extended onto the bus
   localparam int DAT_W     = 16;  // data word
   localparam int SEL_W     = 2;   // byte lanes

   //****************************************
   //* address windows
   //****************************************

   // shadow monitor rom, compared on bits 16..13
   localparam logic [3:0] ROM_TAG  = 4'b1110;

   // ram excludes this page in user mode and keeps only it in console mode
   localparam logic [2:0] RAM_HOLE = 3'b111;

   // register blocks, full 17 bit bases
   localparam logic [ADR_W-1:0] UART_BASE = 17'o177560;  // bits 16..3, four regs
   localparam logic [ADR_W-1:0] RK_BASE   = 17'o177400;  // bits 16..4, eight regs
   localparam logic [ADR_W-1:0] MY_BASE   = 17'o172140;  // bits 16..2, two regs

   //****************************************
   //* device codes
   //****************************************
   typedef enum logic [2:0] {
      DEV_NONE,   // unmapped, nobody answers
      DEV_ROM,
      DEV_RAM,
      DEV_UART,   // console port
      DEV_RK,     // rk disk registers
      DEV_MY      // my floppy registers
   } dev_e;

endpackage
